// File: Makefile
TOP = tb_id_stage

.PHONY: all build run lint clean

all: run

build:
	verilator --binary -f project.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "TEST OK"

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: common/id_defines.svh
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// datapath and register file sizes
`define ID_DATA_W     32
`define ID_REG_ADDR_W 5
`define ID_REG_COUNT  32

// jal writes its return address here
`define ID_LINK_REG   31

// byte distance between sequential instructions
`define ID_PC_STEP    4

`endif

// File: common/id_pkg.sv
`include "id_defines.svh"

package id_pkg;

    typedef logic [`ID_DATA_W-1:0]     word_t;
    typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_NONE = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_AND  = 4'd5,
        ALU_NOR  = 4'd6,
        ALU_OR   = 4'd7,
        ALU_XOR  = 4'd8,
        ALU_SLL  = 4'd9,
        ALU_SRL  = 4'd10,
        ALU_SRA  = 4'd11,
        ALU_LUI  = 4'd12
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC1_RS = 2'd0,
        SRC1_PC = 2'd1,
        SRC1_SA = 2'd2
    } src1_sel_e;

    typedef enum logic [1:0] {
        SRC2_RT    = 2'd0,
        SRC2_SIMM  = 2'd1,
        SRC2_ZIMM  = 2'd2,
        SRC2_EIGHT = 2'd3
    } src2_sel_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_BEQ  = 3'd1,
        BR_BNE  = 3'd2,
        BR_JABS = 3'd3,
        BR_JREG = 3'd4
    } br_kind_e;

endpackage

// File: decode/inst_decoder.sv
`include "id_defines.svh"

module inst_decoder (
    input  id_pkg::word_t     inst_i,
    output id_pkg::alu_op_e   alu_op_o,
    output id_pkg::src1_sel_e src1_sel_o,
    output id_pkg::src2_sel_e src2_sel_o,
    output logic              rf_we_o,
    output id_pkg::reg_addr_t rf_waddr_o,
    output logic              rf_res_from_mem_o,
    output logic              mem_en_o,
    output logic              mem_we_o,
    output id_pkg::br_kind_e  br_kind_o,
    output logic              load_o
);
    import id_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [4:0] sa;
    alu_op_e    r_op;
    logic       is_shift;
    logic       fields_ok;
    logic       wr_en;
    reg_addr_t  wr_addr;

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign sa     = inst_i[10:6];
    assign funct  = inst_i[5:0];

    // register format operation from the function field
    always_comb begin
        case (funct)
            6'b100001: r_op = ALU_ADD;
            6'b100011: r_op = ALU_SUB;
            6'b100100: r_op = ALU_AND;
            6'b100101: r_op = ALU_OR;
            6'b100110: r_op = ALU_XOR;
            6'b100111: r_op = ALU_NOR;
            6'b101010: r_op = ALU_SLT;
            6'b101011: r_op = ALU_SLTU;
            6'b000000: r_op = ALU_SLL;
            6'b000010: r_op = ALU_SRL;
            6'b000011: r_op = ALU_SRA;
            default:   r_op = ALU_NONE;
        endcase
    end

    // shifts take sa and need rs zero, the rest need sa zero
    assign is_shift  = (r_op == ALU_SLL) || (r_op == ALU_SRL) || (r_op == ALU_SRA);
    assign fields_ok = is_shift ? (rs == '0) : (sa == '0);

    always_comb begin
        alu_op_o          = ALU_NONE;
        src1_sel_o        = SRC1_RS;
        src2_sel_o        = SRC2_RT;
        wr_en             = 1'b0;
        wr_addr           = '0;
        rf_res_from_mem_o = 1'b0;
        mem_en_o          = 1'b0;
        mem_we_o          = 1'b0;
        br_kind_o         = BR_NONE;
        case (opcode)
            6'b000000: begin
                if (r_op != ALU_NONE && fields_ok) begin
                    alu_op_o = r_op;
                    wr_en    = 1'b1;
                    wr_addr  = rd;
                    if (is_shift) begin
                        src1_sel_o = SRC1_SA;
                    end
                end else if (funct == 6'b001000 && rt == '0 && rd == '0 && sa == '0) begin
                    br_kind_o = BR_JREG;
                end
            end
            6'b001001: begin
                alu_op_o   = ALU_ADD;
                src2_sel_o = SRC2_SIMM;
                wr_en      = 1'b1;
                wr_addr    = rt;
            end
            6'b001101: begin
                alu_op_o   = ALU_OR;
                src2_sel_o = SRC2_ZIMM;
                wr_en      = 1'b1;
                wr_addr    = rt;
            end
            6'b001111: begin
                alu_op_o   = ALU_LUI;
                src2_sel_o = SRC2_SIMM;
                wr_en      = 1'b1;
                wr_addr    = rt;
            end
            6'b100011: begin
                alu_op_o          = ALU_ADD;
                src2_sel_o        = SRC2_SIMM;
                wr_en             = 1'b1;
                wr_addr           = rt;
                rf_res_from_mem_o = 1'b1;
                mem_en_o          = 1'b1;
            end
            6'b101011: begin
                alu_op_o   = ALU_ADD;
                src2_sel_o = SRC2_SIMM;
                mem_en_o   = 1'b1;
                mem_we_o   = 1'b1;
            end
            6'b000100: br_kind_o = BR_BEQ;
            6'b000101: br_kind_o = BR_BNE;
            6'b000010: br_kind_o = BR_JABS;
            6'b000011: begin
                // return address is pc + 8
                br_kind_o  = BR_JABS;
                alu_op_o   = ALU_ADD;
                src1_sel_o = SRC1_PC;
                src2_sel_o = SRC2_EIGHT;
                wr_en      = 1'b1;
                wr_addr    = reg_addr_t'(`ID_LINK_REG);
            end
            default: ;
        endcase
    end

    // r0 is never a real destination
    assign rf_we_o    = wr_en && (wr_addr != '0);
    assign rf_waddr_o = wr_addr;
    assign load_o     = mem_en_o && !mem_we_o;

endmodule

// File: logic/branch_resolve.sv
`include "id_defines.svh"

module branch_resolve (
    input  id_pkg::word_t    pc_i,
    input  id_pkg::word_t    inst_i,
    input  id_pkg::br_kind_e br_kind_i,
    input  id_pkg::word_t    rdata1_i,
    input  id_pkg::word_t    rdata2_i,
    output logic             br_taken_o,
    output id_pkg::word_t    br_target_o
);
    import id_pkg::*;

    word_t pc_next;
    word_t br_offset;
    word_t branch_target;
    word_t jump_target;
    logic  ops_equal;

    assign pc_next       = pc_i + word_t'(`ID_PC_STEP);
    assign br_offset     = {{(`ID_DATA_W-18){inst_i[15]}}, inst_i[15:0], 2'b00};
    assign branch_target = pc_next + br_offset;
    // region of the current pc plus the 26-bit index
    assign jump_target   = {pc_i[`ID_DATA_W-1 -: 4], inst_i[25:0], 2'b00};
    assign ops_equal     = (rdata1_i == rdata2_i);

    always_comb begin
        br_taken_o  = 1'b0;
        br_target_o = '0;
        case (br_kind_i)
            BR_BEQ: begin
                br_taken_o  = ops_equal;
                br_target_o = ops_equal ? branch_target : '0;
            end
            BR_BNE: begin
                br_taken_o  = !ops_equal;
                br_target_o = ops_equal ? '0 : branch_target;
            end
            BR_JABS: begin
                br_taken_o  = 1'b1;
                br_target_o = jump_target;
            end
            BR_JREG: begin
                br_taken_o  = 1'b1;
                br_target_o = rdata1_i;
            end
            default: ;
        endcase
    end

endmodule

// File: logic/id_stage.sv
module id_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall_id_i,
    input  logic              stall_ex_i,
    input  id_pkg::word_t     pc_i,
    input  logic              inst_valid_i,
    input  id_pkg::word_t     inst_rdata_i,
    input  logic              ex_we_i,
    input  id_pkg::reg_addr_t ex_waddr_i,
    input  id_pkg::word_t     ex_wdata_i,
    input  logic              mem_we_i,
    input  id_pkg::reg_addr_t mem_waddr_i,
    input  id_pkg::word_t     mem_wdata_i,
    input  logic              wb_we_i,
    input  id_pkg::reg_addr_t wb_waddr_i,
    input  id_pkg::word_t     wb_wdata_i,
    output logic              stallreq_o,
    output id_pkg::alu_op_e   alu_op_o,
    output id_pkg::src1_sel_e src1_sel_o,
    output id_pkg::src2_sel_e src2_sel_o,
    output logic              mem_en_o,
    output logic              mem_we_o,
    output logic              rf_we_o,
    output id_pkg::reg_addr_t rf_waddr_o,
    output logic              rf_res_from_mem_o,
    output id_pkg::word_t     pc_o,
    output id_pkg::word_t     inst_o,
    output id_pkg::word_t     rdata1_o,
    output id_pkg::word_t     rdata2_o,
    output logic              br_taken_o,
    output id_pkg::word_t     br_target_o
);
    import id_pkg::*;

    word_t    pc_r;
    logic     valid_r;
    word_t    inst;
    alu_op_e  dec_alu_op;
    br_kind_e br_kind;
    logic     load;

    // fetch-to-decode register
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_r    <= '0;
            valid_r <= 1'b0;
        end else if (stall_id_i && !stall_ex_i) begin
            // execute moves on, so insert a bubble
            pc_r    <= '0;
            valid_r <= 1'b0;
        end else if (!stall_id_i) begin
            pc_r    <= pc_i;
            valid_r <= inst_valid_i;
        end
    end

    assign inst   = valid_r ? inst_rdata_i : '0;
    assign pc_o   = pc_r;
    assign inst_o = inst;

    inst_decoder i_inst_decoder (
        .inst_i            (inst),
        .alu_op_o          (dec_alu_op),
        .src1_sel_o        (src1_sel_o),
        .src2_sel_o        (src2_sel_o),
        .rf_we_o           (rf_we_o),
        .rf_waddr_o        (rf_waddr_o),
        .rf_res_from_mem_o (rf_res_from_mem_o),
        .mem_en_o          (mem_en_o),
        .mem_we_o          (mem_we_o),
        .br_kind_o         (br_kind),
        .load_o            (load)
    );

    // a bubble decodes as a nop with no ALU work
    assign alu_op_o   = valid_r ? dec_alu_op : ALU_NONE;
    assign stallreq_o = load;

    operand_forward i_operand_forward (
        .clk         (clk),
        .inst_i      (inst),
        .ex_we_i     (ex_we_i),
        .mem_we_i    (mem_we_i),
        .wb_we_i     (wb_we_i),
        .ex_waddr_i  (ex_waddr_i),
        .mem_waddr_i (mem_waddr_i),
        .wb_waddr_i  (wb_waddr_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wdata_i (mem_wdata_i),
        .wb_wdata_i  (wb_wdata_i),
        .rdata1_o    (rdata1_o),
        .rdata2_o    (rdata2_o)
    );

    branch_resolve i_branch_resolve (
        .pc_i        (pc_r),
        .inst_i      (inst),
        .br_kind_i   (br_kind),
        .rdata1_i    (rdata1_o),
        .rdata2_i    (rdata2_o),
        .br_taken_o  (br_taken_o),
        .br_target_o (br_target_o)
    );

endmodule

// File: operand/gpr_file.sv
`include "id_defines.svh"

module gpr_file (
    input  logic              clk,
    input  id_pkg::reg_addr_t raddr1_i,
    input  id_pkg::reg_addr_t raddr2_i,
    output id_pkg::word_t     rdata1_o,
    output id_pkg::word_t     rdata2_o,
    input  logic              we_i,
    input  id_pkg::reg_addr_t waddr_i,
    input  id_pkg::word_t     wdata_i
);
    import id_pkg::*;

    word_t regs [`ID_REG_COUNT];

    always_ff @(posedge clk) begin
        if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 hardwired to zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: operand/operand_forward.sv
module operand_forward (
    input  logic              clk,
    input  id_pkg::word_t     inst_i,
    input  logic              ex_we_i,
    input  logic              mem_we_i,
    input  logic              wb_we_i,
    input  id_pkg::reg_addr_t ex_waddr_i,
    input  id_pkg::reg_addr_t mem_waddr_i,
    input  id_pkg::reg_addr_t wb_waddr_i,
    input  id_pkg::word_t     ex_wdata_i,
    input  id_pkg::word_t     mem_wdata_i,
    input  id_pkg::word_t     wb_wdata_i,
    output id_pkg::word_t     rdata1_o,
    output id_pkg::word_t     rdata2_o
);
    import id_pkg::*;

    reg_addr_t rs;
    reg_addr_t rt;
    word_t     file_rdata1;
    word_t     file_rdata2;

    assign rs = inst_i[25:21];
    assign rt = inst_i[20:16];

    gpr_file i_gpr_file (
        .clk      (clk),
        .raddr1_i (rs),
        .raddr2_i (rt),
        .rdata1_o (file_rdata1),
        .rdata2_o (file_rdata2),
        .we_i     (wb_we_i),
        .waddr_i  (wb_waddr_i),
        .wdata_i  (wb_wdata_i)
    );

    // youngest matching result wins
    function automatic word_t fwd_sel(input reg_addr_t src, input word_t file_data);
        if (src == '0) begin
            return '0;
        end else if (ex_we_i && ex_waddr_i == src) begin
            return ex_wdata_i;
        end else if (mem_we_i && mem_waddr_i == src) begin
            return mem_wdata_i;
        end else if (wb_we_i && wb_waddr_i == src) begin
            return wb_wdata_i;
        end
        return file_data;
    endfunction

    always_comb begin
        rdata1_o = fwd_sel(rs, file_rdata1);
        rdata2_o = fwd_sel(rt, file_rdata2);
    end

endmodule

// File: project.f
+incdir+common
common/id_pkg.sv
decode/inst_decoder.sv
operand/gpr_file.sv
operand/operand_forward.sv
logic/branch_resolve.sv
logic/id_stage.sv
tb/id_checker.sv
tb/tb_id_stage.sv

// File: tb/id_checker.sv
`include "id_defines.svh"

module id_checker (
    input  logic              clk,
    input  logic              check_en_i,
    input  logic [3:0]        test_id_i,
    input  logic [17:0]       exp_ctl_i,
    input  id_pkg::word_t     exp_rdata1_i,
    input  id_pkg::word_t     exp_rdata2_i,
    input  id_pkg::word_t     exp_target_i,
    input  id_pkg::word_t     exp_pc_i,
    input  id_pkg::word_t     exp_inst_i,
    input  logic              stallreq_i,
    input  id_pkg::alu_op_e   alu_op_i,
    input  id_pkg::src1_sel_e src1_sel_i,
    input  id_pkg::src2_sel_e src2_sel_i,
    input  logic              mem_en_i,
    input  logic              mem_we_i,
    input  logic              rf_we_i,
    input  id_pkg::reg_addr_t rf_waddr_i,
    input  logic              rf_res_from_mem_i,
    input  id_pkg::word_t     pc_i,
    input  id_pkg::word_t     inst_i,
    input  id_pkg::word_t     rdata1_i,
    input  id_pkg::word_t     rdata2_i,
    input  logic              br_taken_i,
    input  id_pkg::word_t     br_target_i,
    output int                errors_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import id_pkg::*;

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1:    return "reset_bubble";
            4'd2:    return "decode";
            4'd3:    return "forwarding";
            4'd4:    return "branch_jump";
            4'd5:    return "stall";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare(input string field, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            errors_o = errors_o + 1;
            $display("mismatch test %s field %s expected %h actual %h",
                     test_name(test_id_i), field, expected, actual);
        end
    endtask

    // expected control word holds we, waddr, alu_op, src1, src2, mem_en, mem_we,
    // taken and stallreq from the top down
    initial begin
        errors_o = 0;
        forever begin
            @(posedge clk);
            // just before the next edge
            #99;
            if (check_en_i) begin
                compare("rf_we", 32'(exp_ctl_i[17]), 32'(rf_we_i));
                compare("rf_waddr", 32'(exp_ctl_i[12 +: `ID_REG_ADDR_W]), 32'(rf_waddr_i));
                compare("alu_op", 32'(exp_ctl_i[11:8]), 32'(alu_op_i));
                compare("src1_sel", 32'(exp_ctl_i[7:6]), 32'(src1_sel_i));
                compare("src2_sel", 32'(exp_ctl_i[5:4]), 32'(src2_sel_i));
                compare("mem_en", 32'(exp_ctl_i[3]), 32'(mem_en_i));
                compare("mem_we", 32'(exp_ctl_i[2]), 32'(mem_we_i));
                compare("br_taken", 32'(exp_ctl_i[1]), 32'(br_taken_i));
                compare("stallreq", 32'(exp_ctl_i[0]), 32'(stallreq_i));
                // only lw takes its result from memory
                compare("rf_res_from_mem", 32'(exp_ctl_i[0]), 32'(rf_res_from_mem_i));
                compare("rdata1", exp_rdata1_i, rdata1_i);
                compare("rdata2", exp_rdata2_i, rdata2_i);
                compare("br_target", exp_target_i, br_target_i);
                compare("pc", exp_pc_i, pc_i);
                compare("inst", exp_inst_i, inst_i);
            end
        end
    end

endmodule

// File: tb/id_trace.txt
// stall_id.stall_ex.valid pc inst ex{we,addr} ex_data mem{we,addr} mem_data wb{we,addr} wb_data
// exp{we,waddr,alu,src1,src2,mem_en,mem_we,taken,stallreq} exp_rdata1 exp_rdata2 exp_target test
0 00000000 00000000 00 00000000 00 00000000 00 00000000 00080 00000000 00000000 00000000 1
1 00400000 00221821 00 00000000 22 00000022 21 11111111 23100 11111111 00000022 00000000 2
1 00400004 00222023 00 00000000 00 00000000 22 22222222 24200 11111111 22222222 00000000 2
1 00400008 0022282a 00 00000000 00 00000000 00 00000000 25300 11111111 22222222 00000000 2
1 0040000c 0022302b 00 00000000 00 00000000 00 00000000 26400 11111111 22222222 00000000 2
1 00400010 00223824 00 00000000 00 00000000 00 00000000 27500 11111111 22222222 00000000 2
1 00400014 00224025 00 00000000 00 00000000 00 00000000 28700 11111111 22222222 00000000 2
1 00400018 00224826 00 00000000 00 00000000 00 00000000 29800 11111111 22222222 00000000 2
1 0040001c 00225027 00 00000000 00 00000000 00 00000000 2a600 11111111 22222222 00000000 2
1 00400020 00025900 00 00000000 00 00000000 00 00000000 2b980 00000000 22222222 00000000 2
1 00400024 00026102 00 00000000 00 00000000 00 00000000 2ca80 00000000 22222222 00000000 2
1 00400028 00026903 00 00000000 00 00000000 00 00000000 2db80 00000000 22222222 00000000 2
1 0040002c 2422fffc 00 00000000 00 00000000 00 00000000 22110 11111111 22222222 00000000 2
1 00400030 342200ff 00 00000000 00 00000000 00 00000000 22720 11111111 22222222 00000000 2
1 00400034 3c021234 00 00000000 00 00000000 00 00000000 22c10 00000000 22222222 00000000 2
1 00400038 8c220008 00 00000000 00 00000000 00 00000000 22119 11111111 22222222 00000000 2
1 0040003c ac22000c 00 00000000 00 00000000 00 00000000 0011c 11111111 22222222 00000000 2
1 00400040 00220021 00 00000000 00 00000000 00 00000000 00100 11111111 22222222 00000000 2
1 00400044 00221821 21 aaaa0001 21 bbbb0001 00 00000000 23100 aaaa0001 22222222 00000000 3
1 00400048 00221821 25 aaaa0002 21 bbbb0002 00 00000000 23100 bbbb0002 22222222 00000000 3
1 0040004c 00011821 20 deadbeef 00 00000000 00 00000000 23100 00000000 11111111 00000000 3
1 00400050 00001821 00 00000000 00 00000000 34 20202020 23100 00000000 00000000 00000000 3
1 00400054 02801821 00 00000000 00 00000000 00 00000000 23100 20202020 00000000 00000000 3
1 00400058 10210004 00 00000000 00 00000000 00 00000000 00002 11111111 11111111 0040006c 4
1 0040005c 1022fffe 00 00000000 00 00000000 00 00000000 00000 11111111 22222222 00000000 4
1 00400060 1422fffe 00 00000000 00 00000000 00 00000000 00002 11111111 22222222 0040005c 4
1 00400064 14210004 00 00000000 00 00000000 00 00000000 00000 11111111 11111111 00000000 4
1 a0000010 08000040 00 00000000 00 00000000 00 00000000 00002 00000000 00000000 a0000100 4
1 0040006c 0c000080 00 00000000 00 00000000 00 00000000 3f172 00000000 00000000 00000200 4
1 00400070 00200008 00 00000000 00 00000000 00 00000000 00002 11111111 00000000 11111111 4
5 00400074 00221821 00 00000000 00 00000000 00 00000000 00080 00000000 00000000 00000000 5
1 00400078 00221821 00 00000000 00 00000000 00 00000000 23100 11111111 22222222 00000000 5
6 0040007c 00221821 00 00000000 00 00000000 00 00000000 23100 11111111 22222222 00000000 5
1 00400080 10210004 00 00000000 00 00000000 00 00000000 00002 11111111 11111111 00400094 5

// File: tb/tb_id_stage.sv
module tb_id_stage;
    timeunit 1ns;
    timeprecision 1ps;

    import id_pkg::*;

    localparam string TRACE_FILE     = "tb/id_trace.txt";
    localparam int    FIELDS         = 14;
    localparam int    TRACE_LINES    = 34;
    localparam int    RESET_CYCLES   = 3;
    localparam int    TIMEOUT_MARGIN = 10;
    localparam int    CYCLE_LIMIT    = RESET_CYCLES + TRACE_LINES + TIMEOUT_MARGIN;

    logic [31:0] trace [0:FIELDS*TRACE_LINES-1];

    logic      clk;
    logic      rst;
    logic      stall_id;
    logic      stall_ex;
    word_t     pc;
    logic      inst_valid;
    word_t     inst_rdata;
    logic      ex_we;
    reg_addr_t ex_waddr;
    word_t     ex_wdata;
    logic      mem_we_fwd;
    reg_addr_t mem_waddr;
    word_t     mem_wdata;
    logic      wb_we;
    reg_addr_t wb_waddr;
    word_t     wb_wdata;

    logic      stallreq;
    alu_op_e   alu_op;
    src1_sel_e src1_sel;
    src2_sel_e src2_sel;
    logic      mem_en;
    logic      mem_we;
    logic      rf_we;
    reg_addr_t rf_waddr;
    logic      rf_res_from_mem;
    word_t     pc_out;
    word_t     inst_out;
    word_t     rdata1;
    word_t     rdata2;
    logic      br_taken;
    word_t     br_target;

    logic        check_en;
    logic [3:0]  test_id;
    logic [17:0] exp_ctl;
    word_t       exp_rdata1;
    word_t       exp_rdata2;
    word_t       exp_target;
    word_t       exp_pc;
    word_t       exp_inst;
    word_t       held_pc;
    logic        held_valid;
    int          errors;
    int          cycle_cnt;

    id_stage i_dut (
        .clk               (clk),
        .rst               (rst),
        .stall_id_i        (stall_id),
        .stall_ex_i        (stall_ex),
        .pc_i              (pc),
        .inst_valid_i      (inst_valid),
        .inst_rdata_i      (inst_rdata),
        .ex_we_i           (ex_we),
        .ex_waddr_i        (ex_waddr),
        .ex_wdata_i        (ex_wdata),
        .mem_we_i          (mem_we_fwd),
        .mem_waddr_i       (mem_waddr),
        .mem_wdata_i       (mem_wdata),
        .wb_we_i           (wb_we),
        .wb_waddr_i        (wb_waddr),
        .wb_wdata_i        (wb_wdata),
        .stallreq_o        (stallreq),
        .alu_op_o          (alu_op),
        .src1_sel_o        (src1_sel),
        .src2_sel_o        (src2_sel),
        .mem_en_o          (mem_en),
        .mem_we_o          (mem_we),
        .rf_we_o           (rf_we),
        .rf_waddr_o        (rf_waddr),
        .rf_res_from_mem_o (rf_res_from_mem),
        .pc_o              (pc_out),
        .inst_o            (inst_out),
        .rdata1_o          (rdata1),
        .rdata2_o          (rdata2),
        .br_taken_o        (br_taken),
        .br_target_o       (br_target)
    );

    id_checker i_checker (
        .clk               (clk),
        .check_en_i        (check_en),
        .test_id_i         (test_id),
        .exp_ctl_i         (exp_ctl),
        .exp_rdata1_i      (exp_rdata1),
        .exp_rdata2_i      (exp_rdata2),
        .exp_target_i      (exp_target),
        .exp_pc_i          (exp_pc),
        .exp_inst_i        (exp_inst),
        .stallreq_i        (stallreq),
        .alu_op_i          (alu_op),
        .src1_sel_i        (src1_sel),
        .src2_sel_i        (src2_sel),
        .mem_en_i          (mem_en),
        .mem_we_i          (mem_we),
        .rf_we_i           (rf_we),
        .rf_waddr_i        (rf_waddr),
        .rf_res_from_mem_i (rf_res_from_mem),
        .pc_i              (pc_out),
        .inst_i            (inst_out),
        .rdata1_i          (rdata1),
        .rdata2_i          (rdata2),
        .br_taken_i        (br_taken),
        .br_target_i       (br_target),
        .errors_o          (errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // pc, valid and stall bits lead the rest of the line by one cycle
    task automatic fetch_inputs(input int n);
        logic [31:0] ctl;
        ctl        = trace[n*FIELDS];
        stall_id   = ctl[2];
        stall_ex   = ctl[1];
        inst_valid = ctl[0];
        pc         = trace[n*FIELDS+1];
    endtask

    task automatic decode_inputs(input int n);
        logic [31:0] fwd;
        logic [31:0] ctl;
        ctl = trace[n*FIELDS];
        // line 0 is captured while rst is high
        if (n > 0) begin
            if (ctl[2] && !ctl[1]) begin
                held_pc    = '0;
                held_valid = 1'b0;
            end else if (!ctl[2]) begin
                held_pc    = trace[n*FIELDS+1];
                held_valid = ctl[0];
            end
        end
        inst_rdata = trace[n*FIELDS+2];
        fwd        = trace[n*FIELDS+3];
        ex_we      = fwd[5];
        ex_waddr   = fwd[4:0];
        ex_wdata   = trace[n*FIELDS+4];
        fwd        = trace[n*FIELDS+5];
        mem_we_fwd = fwd[5];
        mem_waddr  = fwd[4:0];
        mem_wdata  = trace[n*FIELDS+6];
        fwd        = trace[n*FIELDS+7];
        wb_we      = fwd[5];
        wb_waddr   = fwd[4:0];
        wb_wdata   = trace[n*FIELDS+8];
        exp_ctl    = trace[n*FIELDS+9][17:0];
        exp_rdata1 = trace[n*FIELDS+10];
        exp_rdata2 = trace[n*FIELDS+11];
        exp_target = trace[n*FIELDS+12];
        test_id    = trace[n*FIELDS+13][3:0];
        exp_pc     = held_pc;
        exp_inst   = held_valid ? inst_rdata : '0;
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("timeout before trace end");
        $display("errors: %0d", errors + 1);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        stall_id   = 1'b0;
        stall_ex   = 1'b0;
        pc         = '0;
        inst_valid = 1'b0;
        inst_rdata = '0;
        ex_we      = 1'b0;
        ex_waddr   = '0;
        ex_wdata   = '0;
        mem_we_fwd = 1'b0;
        mem_waddr  = '0;
        mem_wdata  = '0;
        wb_we      = 1'b0;
        wb_waddr   = '0;
        wb_wdata   = '0;
        check_en   = 1'b0;
        test_id    = '0;
        exp_ctl    = '0;
        exp_rdata1 = '0;
        exp_rdata2 = '0;
        exp_target = '0;
        exp_pc     = '0;
        exp_inst   = '0;
        held_pc    = '0;
        held_valid = 1'b0;
        $readmemh(TRACE_FILE, trace);

        repeat (RESET_CYCLES - 1) @(posedge clk);
        #1;
        fetch_inputs(0);
        @(posedge clk);
        #1;
        rst = 1'b0;

        for (int n = 0; n < TRACE_LINES; n++) begin
            decode_inputs(n);
            if (n + 1 < TRACE_LINES) begin
                fetch_inputs(n + 1);
            end
            check_en = 1'b1;
            @(posedge clk);
            #1;
        end
        check_en = 1'b0;

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
